// File: sim.f
axi_lite_pkg.sv
pcie_tlp_pkg.sv
sync_fifo.sv
bar_config_regs.sv
mem_req_to_axi.sv
completion_builder.sv
pcie_axi_bridge.sv
tb_pcie_axi_bridge.sv

// File: Bender.yml
package:
  name: pcie_axi_bridge

sources:
  - axi_lite_pkg.sv
  - pcie_tlp_pkg.sv
  - sync_fifo.sv
  - bar_config_regs.sv
  - mem_req_to_axi.sv
  - completion_builder.sv
  - pcie_axi_bridge.sv
  - target: test
    files:
      - tb_pcie_axi_bridge.sv

// File: tb_pcie_axi_bridge.sv
`timescale 1ns/100ps

module tb_pcie_axi_bridge
  import pcie_tlp_pkg::*, axi_lite_pkg::*;
();

  localparam int CLK_PERIOD = 100;
  localparam int N_CFG      = 24;
  localparam int N_WR       = 12;
  localparam int N_RD       = 12;
  localparam int N_ERR      = 4;
  localparam int N_MIX      = 40;
  localparam int N_REBASE   = 4;
  localparam int TOTAL_TXNS = N_CFG + N_WR + N_RD + N_ERR + N_MIX + 2 + N_REBASE;

  logic      axi_clk;
  logic      axi_aresetn;
  pcie_req_t req;
  logic      req_valid;
  logic      req_ready;
  cpl_t      cpl;
  logic      cpl_valid;
  logic      cpl_ready;
  axi_aw_t   m_aw;
  logic      m_aw_valid;
  logic      m_aw_ready;
  axi_w_t    m_w;
  logic      m_w_valid;
  logic      m_w_ready;
  axi_resp_t m_bresp;
  logic      m_bvalid;
  logic      m_bready;
  axi_aw_t   m_ar;
  logic      m_ar_valid;
  logic      m_ar_ready;
  axi_r_t    m_r;
  logic      m_r_valid;
  logic      m_r_ready;
  axi_aw_t   s_aw;
  logic      s_aw_valid;
  logic      s_aw_ready;
  axi_w_t    s_w;
  logic      s_w_valid;
  logic      s_w_ready;
  axi_resp_t s_bresp;
  logic      s_bvalid;
  logic      s_bready;
  axi_aw_t   s_ar;
  logic      s_ar_valid;
  logic      s_ar_ready;
  axi_r_t    s_r;
  logic      s_r_valid;
  logic      s_r_ready;

  string       test_name;
  logic        stall_en;
  logic        b_taken;
  logic        r_taken;
  axi_addr_t   ref_bases [6];
  logic [31:0] ref_mem [axi_addr_t];
  logic [31:0] slave_mem [axi_addr_t];
  pcie_req_t   stim_q [$];
  axi_addr_t   exp_aw_q [$];
  axi_w_t      exp_w_q [$];
  axi_addr_t   exp_ar_q [$];
  cpl_t        exp_cpl_q [$];
  axi_addr_t   aw_q [$];
  axi_w_t      w_q [$];
  axi_resp_t   b_q [$];
  axi_addr_t   r_q [$];

  pcie_axi_bridge dut_i (.*);

  always #(CLK_PERIOD / 2) axi_clk = ~axi_clk;

  ////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////

  task automatic abort_run();
    $display("Verification failed");
    $fatal(1, "Simulation stopped after an error");
  endtask

  task automatic compare_values(input string what, input logic [95:0] expected,
                                input logic [95:0] actual);
    if (expected !== actual) begin
      $display("FAILED %s: expected 0x%0h, actual 0x%0h", what, expected, actual);
      abort_run();
    end
  endtask

  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
                                              input logic [3:0] strb);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = data[8*b +: 8];
      end
    end
    return res;
  endfunction

  // Untouched words hold a pattern of their full address
  function automatic logic [31:0] fill_word(input axi_addr_t a);
    return {a[15:0], a[31:16]} ^ 32'h5A3C_C3A5;
  endfunction

  function automatic logic [31:0] ref_read(input axi_addr_t a);
    return ref_mem.exists(a) ? ref_mem[a] : fill_word(a);
  endfunction

  function automatic logic [31:0] slave_read(input axi_addr_t a);
    return slave_mem.exists(a) ? slave_mem[a] : fill_word(a);
  endfunction

  function automatic logic [6:0] lower_addr_of(input logic [31:0] addr, input logic [3:0] be);
    logic [1:0] off;
    off = 2'd0;
    for (int i = 3; i >= 0; i--) begin
      if (be[i]) begin
        off = 2'(i);
      end
    end
    return {addr[6:2], off};
  endfunction

  function automatic logic [2:0] byte_count_of(input logic [3:0] be);
    int lo;
    int hi;
    lo = -1;
    hi = -1;
    for (int i = 0; i < 4; i++) begin
      if (be[i]) begin
        if (lo < 0) begin
          lo = i;
        end
        hi = i;
      end
    end
    if (lo < 0) begin
      return 3'd1;
    end
    return 3'(hi - lo + 1);
  endfunction

  function automatic logic roll_ready();
    return !stall_en || ($urandom_range(99) < 60);
  endfunction

  // Random word offset in the aperture with bit 11 as the error flag
  function automatic logic [11:0] pick_offset(input int words, input logic err);
    return {err, 9'($urandom_range(words - 1)), 2'($urandom)};
  endfunction

  function automatic pcie_req_t make_req(input logic write, input int bar,
                                         input logic [11:0] offset);
    pcie_req_t   r;
    logic [31:0] rnd;
    rnd            = $urandom;
    r.bar          = bar_idx_t'(bar);
    r.addr         = {rnd[31:12], offset};
    r.first_be     = 4'($urandom_range(15));
    r.write        = write;
    r.data         = $urandom;
    r.tag          = 8'($urandom);
    r.requester_id = 16'($urandom);
    r.tc           = 3'($urandom);
    r.attr         = 3'($urandom);
    return r;
  endfunction

  ////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////

  function automatic void predict_request(input pcie_req_t r);
    axi_addr_t taddr;
    cpl_t      c;
    taddr = {ref_bases[r.bar][31:12], r.addr[11:2], 2'b00};
    if (r.write) begin
      exp_aw_q.push_back(taddr);
      exp_w_q.push_back('{data: r.data, strb: r.first_be});
      ref_mem[taddr] = merge_bytes(ref_read(taddr), r.data, r.first_be);
    end else begin
      c.tag          = r.tag;
      c.requester_id = r.requester_id;
      c.tc           = r.tc;
      c.attr         = r.attr;
      c.lower_addr   = lower_addr_of(r.addr, r.first_be);
      c.byte_count   = byte_count_of(r.first_be);
      c.status       = r.addr[11] ? 3'd4 : 3'd0;
      c.data         = ref_read(taddr);
      exp_ar_q.push_back(taddr);
      exp_cpl_q.push_back(c);
    end
    stim_q.push_back(r);
  endfunction

  ////////////////////////////////////////////////////
  // Driving tasks
  ////////////////////////////////////////////////////

  task automatic issue_requests();
    while (stim_q.size() > 0) begin
      @(negedge axi_clk);
      if (stall_en && $urandom_range(3) == 0) begin
        req_valid = 1'b0;
      end else begin
        req       = stim_q.pop_front();
        req_valid = 1'b1;
        do @(posedge axi_clk); while (!req_ready);
      end
    end
    @(negedge axi_clk);
    req_valid = 1'b0;
  endtask

  task automatic wait_idle();
    do @(negedge axi_clk);
    while (exp_aw_q.size() + exp_w_q.size() + exp_ar_q.size() + exp_cpl_q.size()
           + b_q.size() + r_q.size() != 0);
  endtask

  task automatic cfg_write(input logic [4:0] offs, input logic [31:0] data,
                           input logic [3:0] strb);
    @(negedge axi_clk);
    s_aw       = '{addr: {27'd0, offs}, prot: 3'b000};
    s_w        = '{data: data, strb: strb};
    s_aw_valid = 1'b1;
    s_w_valid  = 1'b1;
    do @(posedge axi_clk); while (!(s_aw_ready && s_w_ready));
    @(negedge axi_clk);
    s_aw_valid = 1'b0;
    s_w_valid  = 1'b0;
    s_bready   = 1'b1;
    do @(posedge axi_clk); while (!s_bvalid);
    compare_values({test_name, " config bresp"}, 2'b00, s_bresp);
    @(negedge axi_clk);
    s_bready = 1'b0;
    if (offs[4:2] < 6) begin
      ref_bases[offs[4:2]] = merge_bytes(ref_bases[offs[4:2]], data, strb);
    end
  endtask

  task automatic cfg_read(input logic [4:0] offs);
    logic [31:0] expected;
    expected = (offs[4:2] < 6) ? ref_bases[offs[4:2]] : 32'h0;
    @(negedge axi_clk);
    s_ar       = '{addr: {27'd0, offs}, prot: 3'b000};
    s_ar_valid = 1'b1;
    do @(posedge axi_clk); while (!s_ar_ready);
    @(negedge axi_clk);
    s_ar_valid = 1'b0;
    s_r_ready  = 1'b1;
    do @(posedge axi_clk); while (!s_r_valid);
    compare_values($sformatf("%s config read 0x%02h", test_name, offs),
                   {expected, 2'b00}, s_r);
    @(negedge axi_clk);
    s_r_ready = 1'b0;
  endtask

  ////////////////////////////////////////////////////
  // AXI memory slave and monitors
  ////////////////////////////////////////////////////

  always @(negedge axi_clk) begin
    m_aw_ready = roll_ready();
    m_w_ready  = roll_ready();
    m_ar_ready = roll_ready();
    cpl_ready  = stall_en ? ($urandom_range(1) == 1) : 1'b1;
    if (!m_bvalid || b_taken) begin
      b_taken  = 1'b0;
      m_bvalid = (b_q.size() > 0) && roll_ready();
      if (b_q.size() > 0) begin
        m_bresp = b_q[0];
      end
    end
    // Read data comes from memory when the beat is presented
    if (!m_r_valid || r_taken) begin
      r_taken   = 1'b0;
      m_r_valid = (r_q.size() > 0) && roll_ready();
      if (r_q.size() > 0) begin
        m_r.data = slave_read(r_q[0]);
        m_r.resp = r_q[0][11] ? 2'b10 : 2'b00;
      end
    end
  end

  always @(posedge axi_clk) begin : axi_monitor
    axi_addr_t waddr;
    axi_w_t    wbeat;
    if (axi_aresetn) begin
      if (m_aw_valid && m_aw_ready) begin
        if (exp_aw_q.size() == 0) begin
          $display("Write address 0x%h issued with no write pending", m_aw.addr);
          abort_run();
        end
        compare_values({test_name, " aw"}, {exp_aw_q.pop_front(), 3'b000}, m_aw);
        aw_q.push_back(m_aw.addr);
      end
      if (m_w_valid && m_w_ready) begin
        if (exp_w_q.size() == 0) begin
          $display("Write data issued with no write pending");
          abort_run();
        end
        compare_values({test_name, " w"}, exp_w_q.pop_front(), m_w);
        w_q.push_back(m_w);
      end
      while (aw_q.size() > 0 && w_q.size() > 0) begin
        waddr            = aw_q.pop_front();
        wbeat            = w_q.pop_front();
        slave_mem[waddr] = merge_bytes(slave_read(waddr), wbeat.data, wbeat.strb);
        b_q.push_back(waddr[11] ? 2'b10 : 2'b00);
      end
      if (m_bvalid && m_bready) begin
        void'(b_q.pop_front());
        b_taken = 1'b1;
      end
      if (m_ar_valid && m_ar_ready) begin
        if (exp_ar_q.size() == 0) begin
          $display("Read address 0x%h issued with no read pending", m_ar.addr);
          abort_run();
        end
        compare_values({test_name, " ar"}, {exp_ar_q.pop_front(), 3'b000}, m_ar);
        r_q.push_back(m_ar.addr);
      end
      if (m_r_valid && m_r_ready) begin
        void'(r_q.pop_front());
        r_taken = 1'b1;
      end
      if (cpl_valid && cpl_ready) begin
        if (exp_cpl_q.size() == 0) begin
          $display("Completion with tag 0x%h arrived with no read pending", cpl.tag);
          abort_run();
        end
        compare_values({test_name, " completion"}, exp_cpl_q.pop_front(), cpl);
      end
    end
  end

  initial begin
    #(CLK_PERIOD * (200 * TOTAL_TXNS + 20));
    $display("Timeout: transactions did not complete within %0d cycles",
             200 * TOTAL_TXNS + 20);
    abort_run();
  end

  ////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////

  initial begin
    logic [31:0] new_base;
    pcie_req_t   wr_req;
    void'($urandom(5));
    axi_clk     = 1'b0;
    axi_aresetn = 1'b0;
    req         = '0;
    req_valid   = 1'b0;
    cpl_ready   = 1'b0;
    m_aw_ready  = 1'b0;
    m_w_ready   = 1'b0;
    m_bresp     = 2'b00;
    m_bvalid    = 1'b0;
    m_ar_ready  = 1'b0;
    m_r         = '0;
    m_r_valid   = 1'b0;
    s_aw        = '0;
    s_aw_valid  = 1'b0;
    s_w         = '0;
    s_w_valid   = 1'b0;
    s_bready    = 1'b0;
    s_ar        = '0;
    s_ar_valid  = 1'b0;
    s_r_ready   = 1'b0;
    stall_en    = 1'b0;
    b_taken     = 1'b0;
    r_taken     = 1'b0;
    test_name   = "reset";
    ref_bases[0] = 32'h6000_0000;
    ref_bases[1] = 32'h5000_0000;
    ref_bases[2] = 32'h4000_0000;
    ref_bases[3] = 32'h3000_0000;
    ref_bases[4] = 32'h2000_0000;
    ref_bases[5] = 32'h1000_0000;

    repeat (3) @(posedge axi_clk);
    compare_values({test_name, " valids"}, 7'b0,
                   {req_ready, cpl_valid, m_aw_valid, m_w_valid, m_ar_valid,
                    s_bvalid, s_r_valid});
    @(negedge axi_clk);
    axi_aresetn = 1'b1;
    do @(posedge axi_clk); while (!req_ready);

    test_name = "cfg_reset";
    for (int i = 0; i < 6; i++) begin
      cfg_read(5'(4 * i));
    end
    test_name = "cfg_strobe";
    for (int i = 0; i < 6; i++) begin
      cfg_write(5'(4 * i), $urandom, 4'($urandom_range(15)));
      cfg_read(5'(4 * i));
    end
    test_name = "cfg_unmapped";
    cfg_write(5'h18, $urandom, 4'hf);
    cfg_read(5'h18);
    cfg_write(5'h1c, $urandom, 4'hf);
    cfg_read(5'h1c);

    test_name = "writes";
    for (int i = 0; i < N_WR; i++) begin
      predict_request(make_req(1'b1, $urandom_range(5), pick_offset(8, 1'b0)));
    end
    issue_requests();
    wait_idle();

    test_name = "reads";
    for (int i = 0; i < N_RD; i++) begin
      predict_request(make_req(1'b0, $urandom_range(5), pick_offset(8, 1'b0)));
    end
    issue_requests();
    wait_idle();

    test_name = "slverr_reads";
    for (int i = 0; i < N_ERR; i++) begin
      predict_request(make_req(1'b0, $urandom_range(5), pick_offset(8, 1'b1)));
    end
    issue_requests();
    wait_idle();

    // Small address pool so reads and writes collide
    test_name = "mixed_stall";
    stall_en  = 1'b1;
    predict_request(make_req(1'b0, 1, 12'h010));
    wr_req          = make_req(1'b1, 1, 12'h010);
    wr_req.first_be = 4'hf;
    predict_request(wr_req);
    for (int i = 0; i < N_MIX; i++) begin
      predict_request(make_req(1'($urandom_range(1)), $urandom_range(1),
                               pick_offset(4, $urandom_range(7) == 0)));
    end
    issue_requests();
    wait_idle();

    test_name = "rebase";
    new_base  = {4'hc, 16'($urandom), 12'h000};
    cfg_write(5'h08, new_base, 4'hf);
    cfg_read(5'h08);
    predict_request(make_req(1'b1, 2, 12'h020));
    predict_request(make_req(1'b0, 2, 12'h020));
    predict_request(make_req(1'b0, 2, pick_offset(8, 1'b0)));
    predict_request(make_req(1'b1, 2, pick_offset(8, 1'b0)));
    issue_requests();
    wait_idle();

    if (cpl_valid || m_aw_valid || m_w_valid || m_ar_valid) begin
      $display("Bridge still presents a transfer after the last request completed");
      abort_run();
    end else begin
      $display("Verification passed");
      $finish;
    end
  end

endmodule

// File: pcie_axi_bridge.sv
`timescale 1ns/100ps

module pcie_axi_bridge
  import pcie_tlp_pkg::*, axi_lite_pkg::*;
(
  input  logic      axi_clk,
  input  logic      axi_aresetn,
  input  pcie_req_t req,
  input  logic      req_valid,
  output logic      req_ready,
  output cpl_t      cpl,
  output logic      cpl_valid,
  input  logic      cpl_ready,
  output axi_aw_t   m_aw,
  output logic      m_aw_valid,
  input  logic      m_aw_ready,
  output axi_w_t    m_w,
  output logic      m_w_valid,
  input  logic      m_w_ready,
  input  axi_resp_t m_bresp,
  input  logic      m_bvalid,
  output logic      m_bready,
  output axi_aw_t   m_ar,
  output logic      m_ar_valid,
  input  logic      m_ar_ready,
  input  axi_r_t    m_r,
  input  logic      m_r_valid,
  output logic      m_r_ready,
  input  axi_aw_t   s_aw,
  input  logic      s_aw_valid,
  output logic      s_aw_ready,
  input  axi_w_t    s_w,
  input  logic      s_w_valid,
  output logic      s_w_ready,
  output axi_resp_t s_bresp,
  output logic      s_bvalid,
  input  logic      s_bready,
  input  axi_aw_t   s_ar,
  input  logic      s_ar_valid,
  output logic      s_ar_ready,
  output axi_r_t    s_r,
  output logic      s_r_valid,
  input  logic      s_r_ready
);

  logic [2:0] rst_sync_q;
  logic       core_resetn;
  bar_bases_t bar_bases;
  pcie_req_t  req_head;
  logic       req_head_valid;
  logic       req_head_ready;
  tag_rec_t   tag_push_rec;
  logic       tag_push;
  logic       tag_full;
  logic       tag_empty;
  tag_rec_t   tag_head;
  logic       tag_valid;
  logic       tag_pop;

  //////////////////////////////////////////////////
  // Reset synchronizer
  //////////////////////////////////////////////////

  // Async assert, release after three edges
  always_ff @(posedge axi_clk or negedge axi_aresetn) begin
    if (!axi_aresetn) begin
      rst_sync_q <= 3'b000;
    end else begin
      rst_sync_q <= {rst_sync_q[1:0], 1'b1};
    end
  end

  assign core_resetn = rst_sync_q[2];

  //////////////////////////////////////////////////
  // Instances
  //////////////////////////////////////////////////

  bar_config_regs bar_config_regs_i (
    .axi_clk     (axi_clk),
    .axi_aresetn (core_resetn),
    .s_aw        (s_aw),
    .s_aw_valid  (s_aw_valid),
    .s_aw_ready  (s_aw_ready),
    .s_w         (s_w),
    .s_w_valid   (s_w_valid),
    .s_w_ready   (s_w_ready),
    .s_bresp     (s_bresp),
    .s_bvalid    (s_bvalid),
    .s_bready    (s_bready),
    .s_ar        (s_ar),
    .s_ar_valid  (s_ar_valid),
    .s_ar_ready  (s_ar_ready),
    .s_r         (s_r),
    .s_r_valid   (s_r_valid),
    .s_r_ready   (s_r_ready),
    .bar_bases   (bar_bases)
  );

  sync_fifo #(
    .T          (pcie_req_t),
    .DEPTH_BITS (REQ_FIFO_BITS)
  ) req_fifo_i (
    .axi_clk     (axi_clk),
    .axi_aresetn (core_resetn),
    .push_data   (req),
    .push_valid  (req_valid),
    .push_ready  (req_ready),
    .pop_data    (req_head),
    .pop_valid   (req_head_valid),
    .pop_ready   (req_head_ready),
    .empty       (),
    .full        ()
  );

  mem_req_to_axi mem_req_to_axi_i (
    .axi_clk     (axi_clk),
    .axi_aresetn (core_resetn),
    .req         (req_head),
    .req_valid   (req_head_valid),
    .req_ready   (req_head_ready),
    .bar_bases   (bar_bases),
    .m_aw        (m_aw),
    .m_aw_valid  (m_aw_valid),
    .m_aw_ready  (m_aw_ready),
    .m_w         (m_w),
    .m_w_valid   (m_w_valid),
    .m_w_ready   (m_w_ready),
    .m_bvalid    (m_bvalid),
    .m_bready    (m_bready),
    .m_ar        (m_ar),
    .m_ar_valid  (m_ar_valid),
    .m_ar_ready  (m_ar_ready),
    .tag_rec     (tag_push_rec),
    .tag_push    (tag_push),
    .tag_full    (tag_full),
    .tag_empty   (tag_empty)
  );

  // Outstanding reads, oldest at the head
  sync_fifo #(
    .T          (tag_rec_t),
    .DEPTH_BITS (OUTSTANDING_BITS)
  ) tag_fifo_i (
    .axi_clk     (axi_clk),
    .axi_aresetn (core_resetn),
    .push_data   (tag_push_rec),
    .push_valid  (tag_push),
    .push_ready  (),
    .pop_data    (tag_head),
    .pop_valid   (tag_valid),
    .pop_ready   (tag_pop),
    .empty       (tag_empty),
    .full        (tag_full)
  );

  completion_builder completion_builder_i (
    .axi_clk     (axi_clk),
    .axi_aresetn (core_resetn),
    .m_r         (m_r),
    .m_r_valid   (m_r_valid),
    .m_r_ready   (m_r_ready),
    .tag_rec     (tag_head),
    .tag_valid   (tag_valid),
    .tag_pop     (tag_pop),
    .cpl         (cpl),
    .cpl_valid   (cpl_valid),
    .cpl_ready   (cpl_ready)
  );

  // Writes are posted, m_bresp is not checked

endmodule

// File: completion_builder.sv
`timescale 1ns/100ps

module completion_builder
  import pcie_tlp_pkg::*, axi_lite_pkg::*;
(
  input  logic     axi_clk,
  input  logic     axi_aresetn,
  input  axi_r_t   m_r,
  input  logic     m_r_valid,
  output logic     m_r_ready,
  input  tag_rec_t tag_rec,
  input  logic     tag_valid,
  output logic     tag_pop,
  output cpl_t     cpl,
  output logic     cpl_valid,
  input  logic     cpl_ready
);

  logic       r_fire;
  logic [2:0] byte_count;

  // R only moves when a record waits and the output slot frees up
  assign m_r_ready = tag_valid && (!cpl_valid || cpl_ready);
  assign r_fire    = m_r_valid && m_r_ready;
  assign tag_pop   = r_fire;

  // Span from lowest to highest enabled byte
  always_comb begin
    casez (tag_rec.first_be)
      4'b1??1: byte_count = 3'd4;
      4'b01?1: byte_count = 3'd3;
      4'b1?10: byte_count = 3'd3;
      4'b0011,
      4'b0110,
      4'b1100: byte_count = 3'd2;
      default: byte_count = 3'd1;
    endcase
  end

  always_ff @(posedge axi_clk) begin
    if (r_fire) begin
      cpl.tag          <= tag_rec.tag;
      cpl.requester_id <= tag_rec.requester_id;
      cpl.tc           <= tag_rec.tc;
      cpl.attr         <= tag_rec.attr;
      cpl.lower_addr   <= tag_rec.lower_addr;
      cpl.byte_count   <= byte_count;
      cpl.status       <= (m_r.resp == AXI_RESP_OKAY) ? CPL_SC : CPL_CA;
      cpl.data         <= m_r.data;
    end
  end

  always_ff @(posedge axi_clk or negedge axi_aresetn) begin
    if (!axi_aresetn) begin
      cpl_valid <= 1'b0;
    end else if (r_fire) begin
      cpl_valid <= 1'b1;
    end else if (cpl_ready) begin
      cpl_valid <= 1'b0;
    end
  end

endmodule

// File: mem_req_to_axi.sv
`timescale 1ns/100ps

module mem_req_to_axi
  import pcie_tlp_pkg::*, axi_lite_pkg::*;
(
  input  logic       axi_clk,
  input  logic       axi_aresetn,
  input  pcie_req_t  req,
  input  logic       req_valid,
  output logic       req_ready,
  input  bar_bases_t bar_bases,
  output axi_aw_t    m_aw,
  output logic       m_aw_valid,
  input  logic       m_aw_ready,
  output axi_w_t     m_w,
  output logic       m_w_valid,
  input  logic       m_w_ready,
  input  logic       m_bvalid,
  output logic       m_bready,
  output axi_aw_t    m_ar,
  output logic       m_ar_valid,
  input  logic       m_ar_ready,
  output tag_rec_t   tag_rec,
  output logic       tag_push,
  input  logic       tag_full,
  input  logic       tag_empty
);

  typedef enum logic [1:0] {ST_IDLE, ST_READ, ST_WRITE, ST_RESP} state_t;

  state_t     state;
  axi_addr_t  base;
  axi_addr_t  addr_q;
  logic       aw_done;
  logic       w_done;
  logic       aw_fire;
  logic       w_fire;
  logic       ar_fire;
  logic [1:0] be_offset;

  //////////////////////////////////////////////////
  // Translation
  //////////////////////////////////////////////////

  always_comb begin
    base = '0;
    for (int i = 0; i < NUM_BARS; i++) begin
      if (req.bar == bar_idx_t'(i)) begin
        base = bar_bases[i];
      end
    end
  end

  // Offset of the lowest enabled byte
  always_comb begin
    casez (req.first_be)
      4'b???1: be_offset = 2'd0;
      4'b??10: be_offset = 2'd1;
      4'b?100: be_offset = 2'd2;
      4'b1000: be_offset = 2'd3;
      default: be_offset = 2'd0;
    endcase
  end

  always_ff @(posedge axi_clk) begin
    if (state == ST_IDLE && req_valid) begin
      addr_q <= {base[31:BAR_APERTURE_BITS], req.addr[BAR_APERTURE_BITS-1:2], 2'b00};
    end
  end

  //////////////////////////////////////////////////
  // AXI channels
  //////////////////////////////////////////////////

  assign m_ar = '{addr: addr_q, prot: 3'b000};
  assign m_aw = '{addr: addr_q, prot: 3'b000};
  assign m_w  = '{data: req.data, strb: req.first_be};

  // Writes wait for every outstanding read to drain
  assign m_ar_valid = (state == ST_READ) && !tag_full;
  assign m_aw_valid = (state == ST_WRITE) && tag_empty && !aw_done;
  assign m_w_valid  = (state == ST_WRITE) && tag_empty && !w_done;
  assign m_bready   = (state == ST_RESP);

  assign ar_fire = m_ar_valid && m_ar_ready;
  assign aw_fire = m_aw_valid && m_aw_ready;
  assign w_fire  = m_w_valid && m_w_ready;

  assign tag_push = ar_fire;
  assign tag_rec  = '{
    tag:          req.tag,
    requester_id: req.requester_id,
    tc:           req.tc,
    attr:         req.attr,
    lower_addr:   {req.addr[6:2], be_offset},
    first_be:     req.first_be
  };

  // Head stays in the FIFO until its transaction is done
  assign req_ready = ar_fire || (m_bready && m_bvalid);

  always_ff @(posedge axi_clk or negedge axi_aresetn) begin
    if (!axi_aresetn) begin
      state   <= ST_IDLE;
      aw_done <= 1'b0;
      w_done  <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (req_valid) begin
            state <= req.write ? ST_WRITE : ST_READ;
          end
        end
        ST_READ: begin
          if (ar_fire) begin
            state <= ST_IDLE;
          end
        end
        ST_WRITE: begin
          aw_done <= aw_done || aw_fire;
          w_done  <= w_done || w_fire;
          if ((aw_done || aw_fire) && (w_done || w_fire)) begin
            aw_done <= 1'b0;
            w_done  <= 1'b0;
            state   <= ST_RESP;
          end
        end
        ST_RESP: begin
          if (m_bvalid) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

// File: bar_config_regs.sv
`timescale 1ns/100ps

module bar_config_regs
  import axi_lite_pkg::*;
(
  input  logic       axi_clk,
  input  logic       axi_aresetn,
  input  axi_aw_t    s_aw,
  input  logic       s_aw_valid,
  output logic       s_aw_ready,
  input  axi_w_t     s_w,
  input  logic       s_w_valid,
  output logic       s_w_ready,
  output axi_resp_t  s_bresp,
  output logic       s_bvalid,
  input  logic       s_bready,
  input  axi_aw_t    s_ar,
  input  logic       s_ar_valid,
  output logic       s_ar_ready,
  output axi_r_t     s_r,
  output logic       s_r_valid,
  input  logic       s_r_ready,
  output bar_bases_t bar_bases
);

  cfg_addr_t wr_addr;
  cfg_addr_t rd_addr;
  logic      wr_en;
  logic      rd_en;
  axi_data_t rd_data;
  axi_data_t rd_data_q;

  assign wr_addr = s_aw.addr[CFG_ADDR_BITS-1:0];
  assign rd_addr = s_ar.addr[CFG_ADDR_BITS-1:0];

  // AW and W are taken in the same cycle
  assign wr_en      = s_aw_valid && s_w_valid && !s_bvalid;
  assign s_aw_ready = s_w_valid && !s_bvalid;
  assign s_w_ready  = s_aw_valid && !s_bvalid;

  assign s_ar_ready = !s_r_valid;
  assign rd_en      = s_ar_valid && s_ar_ready;

  assign s_bresp = AXI_RESP_OKAY;
  assign s_r     = '{data: rd_data_q, resp: AXI_RESP_OKAY};

  always_ff @(posedge axi_clk or negedge axi_aresetn) begin
    if (!axi_aresetn) begin
      bar_bases <= BAR_BASE_RESET;
    end else if (wr_en) begin
      for (int i = 0; i < CFG_NUM_BASES; i++) begin
        if (wr_addr[CFG_ADDR_BITS-1:2] == i) begin
          for (int b = 0; b < $bits(axi_strb_t); b++) begin
            if (s_w.strb[b]) begin
              bar_bases[i][8*b +: 8] <= s_w.data[8*b +: 8];
            end
          end
        end
      end
    end
  end

  // Offsets past the last base decode to zero
  always_comb begin
    rd_data = '0;
    for (int i = 0; i < CFG_NUM_BASES; i++) begin
      if (rd_addr[CFG_ADDR_BITS-1:2] == i) begin
        rd_data = bar_bases[i];
      end
    end
  end

  always_ff @(posedge axi_clk) begin
    if (rd_en) begin
      rd_data_q <= rd_data;
    end
  end

  always_ff @(posedge axi_clk or negedge axi_aresetn) begin
    if (!axi_aresetn) begin
      s_bvalid  <= 1'b0;
      s_r_valid <= 1'b0;
    end else begin
      if (wr_en) begin
        s_bvalid <= 1'b1;
      end else if (s_bready) begin
        s_bvalid <= 1'b0;
      end
      if (rd_en) begin
        s_r_valid <= 1'b1;
      end else if (s_r_ready) begin
        s_r_valid <= 1'b0;
      end
    end
  end

endmodule

// File: sync_fifo.sv
`timescale 1ns/100ps

module sync_fifo #(
  parameter type T          = logic,
  parameter int  DEPTH_BITS = 2
) (
  input  logic axi_clk,
  input  logic axi_aresetn,
  input  T     push_data,
  input  logic push_valid,
  output logic push_ready,
  output T     pop_data,
  output logic pop_valid,
  input  logic pop_ready,
  output logic empty,
  output logic full
);

  T                      mem [2**DEPTH_BITS];
  logic [DEPTH_BITS-1:0] wr_ptr;
  logic [DEPTH_BITS-1:0] rd_ptr;
  logic [DEPTH_BITS:0]   count;
  logic [DEPTH_BITS:0]   count_next;
  logic                  push_fire;
  logic                  pop_fire;

  assign empty     = (count == '0);
  assign full      = count[DEPTH_BITS];
  assign pop_valid = !empty;
  assign pop_data  = mem[rd_ptr];
  assign push_fire = push_valid && push_ready;
  assign pop_fire  = pop_valid && pop_ready;

  always_comb begin
    count_next = count;
    if (push_fire && !pop_fire) begin
      count_next = count + 1'b1;
    end else if (pop_fire && !push_fire) begin
      count_next = count - 1'b1;
    end
  end

  always_ff @(posedge axi_clk) begin
    if (push_fire) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // Ready tracks not-full, held low in reset
  always_ff @(posedge axi_clk or negedge axi_aresetn) begin
    if (!axi_aresetn) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      push_ready <= 1'b0;
    end else begin
      if (push_fire) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop_fire) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count      <= count_next;
      push_ready <= !count_next[DEPTH_BITS];
    end
  end

endmodule

// File: pcie_tlp_pkg.sv
package pcie_tlp_pkg;

  localparam int NUM_BARS          = 6;
  localparam int BAR_APERTURE_BITS = 12;
  localparam int OUTSTANDING_BITS  = 3;
  localparam int REQ_FIFO_BITS     = 2;

  typedef logic [2:0] bar_idx_t;

  // Completion status codes
  localparam logic [2:0] CPL_SC = 3'd0;
  localparam logic [2:0] CPL_CA = 3'd4;

  // One-dword memory request, already decoded
  typedef struct packed {
    bar_idx_t    bar;
    logic [31:0] addr;
    logic [3:0]  first_be;
    logic        write;
    logic [31:0] data;
    logic [7:0]  tag;
    logic [15:0] requester_id;
    logic [2:0]  tc;
    logic [2:0]  attr;
  } pcie_req_t;

  // Kept per outstanding read
  typedef struct packed {
    logic [7:0]  tag;
    logic [15:0] requester_id;
    logic [2:0]  tc;
    logic [2:0]  attr;
    logic [6:0]  lower_addr;
    logic [3:0]  first_be;
  } tag_rec_t;

  typedef struct packed {
    logic [7:0]  tag;
    logic [15:0] requester_id;
    logic [2:0]  tc;
    logic [2:0]  attr;
    logic [6:0]  lower_addr;
    logic [2:0]  byte_count;
    logic [2:0]  status;
    logic [31:0] data;
  } cpl_t;

endpackage

// File: axi_lite_pkg.sv
package axi_lite_pkg;

  localparam int CFG_ADDR_BITS = 5;
  localparam int CFG_NUM_BASES = 6;

  typedef logic [31:0]              axi_addr_t;
  typedef logic [31:0]              axi_data_t;
  typedef logic [3:0]               axi_strb_t;
  typedef logic [1:0]               axi_resp_t;
  typedef logic [CFG_ADDR_BITS-1:0] cfg_addr_t;

  localparam axi_resp_t AXI_RESP_OKAY   = 2'b00;
  localparam axi_resp_t AXI_RESP_SLVERR = 2'b10;

  // Shared by AW and AR
  typedef struct packed {
    axi_addr_t  addr;
    logic [2:0] prot;
  } axi_aw_t;

  typedef struct packed {
    axi_data_t data;
    axi_strb_t strb;
  } axi_w_t;

  typedef struct packed {
    axi_data_t data;
    axi_resp_t resp;
  } axi_r_t;

  typedef axi_addr_t [CFG_NUM_BASES-1:0] bar_bases_t;

  // BAR0 in the lowest word
  localparam bar_bases_t BAR_BASE_RESET = {
    32'h1000_0000, 32'h2000_0000, 32'h3000_0000,
    32'h4000_0000, 32'h5000_0000, 32'h6000_0000
  };

endpackage
